//--- Bender.yml
package:
  name: mpmc

sources:
  - common/mpmc_cfg_pkg.sv
  - common/mpmc_line_pkg.sv
  - hw/mpmc_port_select.sv
  - hw/mpmc_write_mask.sv
  - hw/mpmc_line_store.sv
  - hw/mpmc_read_align.sv
  - hw/mpmc_top.sv
  - target: test
    files:
      - bench/mpmc_assert.sv
      - bench/mpmc_checker.sv
      - bench/mpmc_tb.sv

//--- bench/mpmc_assert.sv
module mpmc_assert (
	input  logic clk,
	input  logic reset,
	input  logic rd_valid,
	input  logic pready_0,
	input  logic pready_1,
	input  logic pready_2,
	input  logic pready_3,
	input  logic [mpmc_cfg_pkg::num_channels-1:0] done
);
	timeunit 1ns;
	timeprecision 1ps;

	// Running count of assertion failures
	int fail_count = 0;

	// ============================================================
	// Completion handshake
	// ============================================================

	// A pready pulse lasts one cycle on every channel
	single_pulse_0: assert property (@(posedge clk) disable iff (reset) pready_0 |=> !pready_0)
		else begin
			$error("pready_0 stayed high for two cycles");
			fail_count++;
		end
	single_pulse_1: assert property (@(posedge clk) disable iff (reset) pready_1 |=> !pready_1)
		else begin
			$error("pready_1 stayed high for two cycles");
			fail_count++;
		end
	single_pulse_2: assert property (@(posedge clk) disable iff (reset) pready_2 |=> !pready_2)
		else begin
			$error("pready_2 stayed high for two cycles");
			fail_count++;
		end
	single_pulse_3: assert property (@(posedge clk) disable iff (reset) pready_3 |=> !pready_3)
		else begin
			$error("pready_3 stayed high for two cycles");
			fail_count++;
		end

	// Only one channel completes per cycle
	done_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(done))
		else begin
			$error("done has more than one bit set");
			fail_count++;
		end

	// Each completion comes from a line that left the store the cycle before
	done_after_read: assert property (@(posedge clk) disable iff (reset) (|done) |-> $past(rd_valid))
		else begin
			$error("pready raised without a line from the store");
			fail_count++;
		end

endmodule

//--- bench/mpmc_checker.sv
module mpmc_checker (
	input  logic clk,
	input  logic reset,
	input  logic [mpmc_cfg_pkg::num_channels-1:0] psel,
	input  logic [mpmc_cfg_pkg::num_channels-1:0] penable,
	input  logic [mpmc_cfg_pkg::num_channels-1:0] pwrite,
	input  logic [31:0] paddr [mpmc_cfg_pkg::num_channels],
	input  logic [127:0] wdata [mpmc_cfg_pkg::num_channels],
	input  logic [15:0] strb [mpmc_cfg_pkg::num_channels],
	input  logic [mpmc_cfg_pkg::num_channels-1:0] pready,
	input  logic [127:0] rdata [mpmc_cfg_pkg::num_channels],
	input  int test_id,
	input  logic test_end,
	input  logic run_end,
	input  int other_errors,
	output int error_total
);
	timeunit 1ns;
	timeprecision 1ps;
	import mpmc_cfg_pkg::*;

	// Byte image of the 4 KiB address window and a flag for bytes ever written
	logic [7:0] model [4096];
	logic written [4096];

	// Arbiter view rebuilt from the APB rules
	logic [num_channels-1:0] in_flight;
	logic [num_channels-1:0] waiting;
	int pend_edge [num_channels];
	int grant_edge [num_channels];
	int rr;
	int cycle;
	int check_errors = 0;
	int check_count = 0;
	int test_mark = 0;

	assign error_total = check_errors + other_errors;

	initial begin
		for (int i = 0; i < 4096; i++)
			written[i] = 1'b0;
	end

	// ============================================================
	// Completion of one transfer
	// ============================================================

	task automatic complete(input int c);
		int nb;
		int base;
		int i;
		logic [127:0] expect_data;
		nb = ch_width[c] / 8;
		// The lane starts at the address rounded down to the channel width
		base = int'(paddr[c][11:0]);
		base = base - base % nb;
		check_count++;
		if (cycle - grant_edge[c] != 4) begin
			check_errors++;
			$display("CHECK FAILED t=%0t pready_%0d latency got %0d expected 4",
				$time, c, cycle - grant_edge[c]);
		end
		if (cycle - pend_edge[c] > 7) begin
			check_errors++;
			$display("Channel %0d waited %0d edges, more than the round-robin bound allows",
				c, cycle - pend_edge[c]);
		end
		if (pwrite[c]) begin
			for (i = 0; i < nb; i++) begin
				if (strb[c][i]) begin
					model[base + i] = wdata[c][8*i +: 8];
					written[base + i] = 1'b1;
				end
			end
		end else begin
			// Bytes never written carry whatever the DUT returns
			expect_data = rdata[c];
			for (i = 0; i < nb; i++) begin
				if (written[base + i])
					expect_data[8*i +: 8] = model[base + i];
			end
			if (rdata[c] !== expect_data) begin
				check_errors++;
				$display("CHECK FAILED t=%0t prdata_%0d got %h expected %h",
					$time, c, rdata[c], expect_data);
			end
		end
	endtask

	function automatic string test_name(input int id);
		case (id)
			1: return "idle after reset";
			2: return "full line read-back";
			3: return "narrow lane merge";
			4: return "concurrent random traffic";
			5: return "continuous round-robin";
			default: return "unnamed";
		endcase
	endfunction

	// ============================================================
	// Edge-by-edge monitor
	// ============================================================

	always @(posedge clk) begin
		logic [num_channels-1:0] pending;
		int cand;
		int grant;
		if (reset) begin
			in_flight = '0;
			waiting = '0;
			rr = 0;
			cycle = 0;
		end else begin
			cycle++;
			for (int c = 0; c < num_channels; c++) begin
				if (pready[c] && in_flight[c]) begin
					complete(c);
				end else if (pready[c]) begin
					check_errors++;
					$display("Channel %0d raised pready at %0t with no request in flight",
						c, $time);
				end
			end
			// The arbiter still counts a completing channel as busy on this edge
			pending = psel & penable & ~in_flight;
			for (int c = 0; c < num_channels; c++) begin
				if (pending[c] && !waiting[c]) begin
					waiting[c] = 1'b1;
					pend_edge[c] = cycle;
				end
			end
			// First pending channel at or after the pointer wins
			grant = -1;
			for (int i = 0; i < num_channels && grant < 0; i++) begin
				cand = (rr + i) % num_channels;
				if (pending[cand])
					grant = cand;
			end
			in_flight = in_flight & ~pready;
			if (grant >= 0) begin
				in_flight[grant] = 1'b1;
				waiting[grant] = 1'b0;
				grant_edge[grant] = cycle;
				rr = (grant + 1) % num_channels;
			end
		end
		if (test_end) begin
			$display("Test %0d %s: %0d errors", test_id, test_name(test_id),
				check_errors + other_errors - test_mark);
			test_mark = check_errors + other_errors;
		end
		if (run_end)
			$display("Summary: %0d tests, %0d checks, %0d errors", test_id, check_count,
				check_errors + other_errors);
	end

endmodule

//--- bench/mpmc_tb.sv
module mpmc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mpmc_cfg_pkg::*;

	logic clk;
	logic reset;

	// Requester side of the four channels indexed by channel number
	logic [num_channels-1:0] psel;
	logic [num_channels-1:0] penable;
	logic [num_channels-1:0] pwrite;
	logic [31:0] paddr [num_channels];
	logic [127:0] wdata [num_channels];
	logic [15:0] strb [num_channels];

	// Completer side with read data zero extended to line width
	wire [num_channels-1:0] pready;
	logic [ch_width[0]-1:0] prdata_0;
	logic [ch_width[1]-1:0] prdata_1;
	logic [ch_width[2]-1:0] prdata_2;
	logic [ch_width[3]-1:0] prdata_3;
	wire [127:0] rdata [num_channels];

	int test_id;
	logic test_end;
	logic run_end;
	int wait_errors;
	int other_errors;
	int error_total;

	bind mpmc_read_align mpmc_assert handshake_check_inst (.*);

	assign rdata[0] = prdata_0;
	assign rdata[1] = 128'(prdata_1);
	assign rdata[2] = 128'(prdata_2);
	assign rdata[3] = 128'(prdata_3);
	assign other_errors = wait_errors
		+ mpmc_top_inst.read_align_inst.handshake_check_inst.fail_count;

	mpmc_top mpmc_top_inst (
		.clk, .reset,
		.psel_0(psel[0]), .penable_0(penable[0]), .pwrite_0(pwrite[0]), .paddr_0(paddr[0]),
		.pwdata_0(wdata[0]), .pstrb_0(strb[0]), .pready_0(pready[0]), .prdata_0,
		.psel_1(psel[1]), .penable_1(penable[1]), .pwrite_1(pwrite[1]), .paddr_1(paddr[1]),
		.pwdata_1(wdata[1][63:0]), .pstrb_1(strb[1][7:0]), .pready_1(pready[1]), .prdata_1,
		.psel_2(psel[2]), .penable_2(penable[2]), .pwrite_2(pwrite[2]), .paddr_2(paddr[2]),
		.pwdata_2(wdata[2][31:0]), .pstrb_2(strb[2][3:0]), .pready_2(pready[2]), .prdata_2,
		.psel_3(psel[3]), .penable_3(penable[3]), .pwrite_3(pwrite[3]), .paddr_3(paddr[3]),
		.pwdata_3(wdata[3][7:0]), .pstrb_3(strb[3][0]), .pready_3(pready[3]), .prdata_3
	);

	mpmc_checker checker_inst (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ============================================================
	// APB requester tasks
	// ============================================================

	function automatic logic [127:0] random_line();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// Setup phase, access phase, then hold until pready shows on a falling edge
	task automatic apb_transfer(input int ch, input logic wr, input logic [31:0] addr,
			input logic [127:0] data, input logic [15:0] be);
		int cnt;
		@(negedge clk);
		psel[ch] = 1'b1;
		penable[ch] = 1'b0;
		pwrite[ch] = wr;
		paddr[ch] = addr;
		wdata[ch] = data;
		strb[ch] = be;
		@(negedge clk);
		penable[ch] = 1'b1;
		cnt = 0;
		while (!pready[ch] && cnt < 20) begin
			@(negedge clk);
			cnt++;
		end
		if (!pready[ch]) begin
			$display("Timeout: channel %0d saw no pready within 20 cycles at %0t", ch, $time);
			wait_errors++;
		end
	endtask

	task automatic release_channel(input int ch);
		@(negedge clk);
		psel[ch] = 1'b0;
		penable[ch] = 1'b0;
	endtask

	task automatic release_all();
		@(negedge clk);
		psel = '0;
		penable = '0;
	endtask

	// Random traffic on one channel with optional idle gaps between transfers
	task automatic run_channel(input int ch, input int count, input int max_gap);
		logic [31:0] addr;
		int gap;
		repeat (count) begin
			addr = $urandom();
			// Four shared lines keep the channels hitting the same bytes
			addr[11:6] = 6'd0;
			apb_transfer(ch, 1'($urandom()), addr, random_line(), 16'($urandom()));
			gap = $urandom_range(max_gap, 0);
			if (gap > 0) begin
				release_channel(ch);
				repeat (gap - 1) @(negedge clk);
			end
		end
	endtask

	task automatic finish_test(input int id);
		@(negedge clk);
		test_id = id;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [31:0] line_addr [8];
		logic [31:0] addr;
		void'($urandom(32'hca96));
		reset = 1'b1;
		psel = '0;
		penable = '0;
		pwrite = '0;
		for (int c = 0; c < num_channels; c++) begin
			paddr[c] = '0;
			wdata[c] = '0;
			strb[c] = '0;
		end
		test_id = 0;
		test_end = 1'b0;
		run_end = 1'b0;
		wait_errors = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// Quiet bus so any pready here is flagged by the checker
		repeat (20) @(negedge clk);
		finish_test(1);

		for (int n = 0; n < 8; n++) begin
			line_addr[n] = $urandom();
			apb_transfer(0, 1'b1, line_addr[n], random_line(), 16'hffff);
		end
		for (int n = 0; n < 8; n++)
			apb_transfer(0, 1'b0, line_addr[n], '0, '0);
		release_all();
		finish_test(2);

		// Full line first so every byte of the merge is known
		// Each channel steps off the bus before the next one starts
		for (int n = 0; n < 6; n++) begin
			addr = $urandom();
			apb_transfer(0, 1'b1, addr, random_line(), 16'hffff);
			release_channel(0);
			for (int c = 1; c < num_channels; c++) begin
				addr[31:12] = 20'($urandom());
				addr[3:0] = 4'($urandom());
				apb_transfer(c, 1'b1, addr, random_line(), 16'($urandom()));
				release_channel(c);
			end
			apb_transfer(0, 1'b0, addr, '0, '0);
		end
		release_all();
		finish_test(3);

		fork
			run_channel(0, 12, 3);
			run_channel(1, 12, 3);
			run_channel(2, 12, 3);
			run_channel(3, 12, 3);
		join
		release_all();
		finish_test(4);

		fork
			run_channel(0, 10, 0);
			run_channel(1, 10, 0);
			run_channel(2, 10, 0);
			run_channel(3, 10, 0);
		join
		release_all();
		finish_test(5);

		repeat (5) @(negedge clk);
		run_end = 1'b1;
		@(negedge clk);
		run_end = 1'b0;
		@(negedge clk);
		if (error_total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- common/mpmc_cfg_pkg.sv
package mpmc_cfg_pkg;

	// ============================================================
	// Channel configuration
	// ============================================================

	// Four APB channels share the memory through one pipeline
	localparam int num_channels = 4;

	// Data width of each channel in bits, indexed by channel number
	// Channel 0 moves a whole line per transfer
	// Channel 3 moves a single byte per transfer
	localparam int ch_width [num_channels] = '{128, 64, 32, 8};

	// ============================================================
	// Memory geometry
	// ============================================================

	// A memory line holds sixteen bytes
	localparam int line_bytes = 16;

	// The store holds this many lines
	// Address bits above the line index are ignored so addresses wrap
	localparam int line_count = 256;

	// Width of the line index taken from the APB address
	// It sits just above the four byte-in-line address bits
	localparam int line_index_bits = 8;

	// ============================================================
	// Types
	// ============================================================

	// Names one of the channels
	// Two bits cover all four, and the round-robin arithmetic
	// relies on it wrapping from channel 3 back to channel 0
	typedef logic [1:0] ch_id_t;

endpackage

//--- common/mpmc_line_pkg.sv
package mpmc_line_pkg;

	// ============================================================
	// Memory line
	// ============================================================

	// One 128-bit line seen three ways
	// The byte view is what the store writes under a byte enable
	// The word and dword views let the read side pick a lane directly
	// Element k of each view starts at bit k times its own width
	typedef union packed {
		logic [mpmc_cfg_pkg::line_bytes-1:0][7:0] bytes;
		logic [mpmc_cfg_pkg::line_bytes/4-1:0][31:0] words;
		logic [mpmc_cfg_pkg::line_bytes/8-1:0][63:0] dwords;
	} mpmc_line_t;

	// Byte enable for a line write
	// Active high with bit k enabling byte k of the line
	// An all-zero value leaves the line unchanged, which is what reads carry
	typedef logic [mpmc_cfg_pkg::line_bytes-1:0] byte_en_t;

endpackage

//--- files.f
common/mpmc_cfg_pkg.sv
common/mpmc_line_pkg.sv
hw/mpmc_port_select.sv
hw/mpmc_write_mask.sv
hw/mpmc_line_store.sv
hw/mpmc_read_align.sv
hw/mpmc_top.sv
bench/mpmc_assert.sv
bench/mpmc_checker.sv
bench/mpmc_tb.sv

//--- hw/mpmc_line_store.sv
module mpmc_line_store (
	input  logic clk,
	input  logic st_valid,
	input  mpmc_cfg_pkg::ch_id_t st_ch,
	input  logic st_write,
	input  logic [mpmc_cfg_pkg::line_index_bits-1:0] st_index,
	input  logic [3:0] st_lane,
	input  mpmc_line_pkg::byte_en_t st_byte_en,
	input  mpmc_line_pkg::mpmc_line_t st_data,
	output logic rd_valid,
	output mpmc_cfg_pkg::ch_id_t rd_ch,
	output logic [3:0] rd_lane,
	output mpmc_line_pkg::mpmc_line_t rd_line
);
	import mpmc_cfg_pkg::*;
	import mpmc_line_pkg::*;

	// Line memory
	mpmc_line_t mem [line_count];

	// Addressed line with this request's write already applied
	mpmc_line_t merged;

	// Every request returns the line as it stands after its own write
	// so a read-back in the same transfer order always sees that data
	always_comb begin
		merged = mem[st_index];
		for (int b = 0; b < line_bytes; b++) begin
			if (st_write && st_byte_en[b])
				merged.bytes[b] = st_data.bytes[b];
		end
	end

	// Byte-enabled write into the array
	always_ff @(posedge clk) begin
		if (st_valid && st_write) begin
			for (int b = 0; b < line_bytes; b++) begin
				if (st_byte_en[b])
					mem[st_index].bytes[b] <= st_data.bytes[b];
			end
		end
	end

	// Registered read side toward lane extraction
	always_ff @(posedge clk) begin
		rd_valid <= st_valid;
		if (st_valid) begin
			rd_ch <= st_ch;
			rd_lane <= st_lane;
			rd_line <= merged;
		end
	end

endmodule

//--- hw/mpmc_port_select.sv
module mpmc_port_select (
	input  logic clk,
	input  logic reset,
	input  logic psel_0,
	input  logic penable_0,
	input  logic pwrite_0,
	input  logic [31:0] paddr_0,
	input  logic [mpmc_cfg_pkg::ch_width[0]-1:0] pwdata_0,
	input  logic [mpmc_cfg_pkg::ch_width[0]/8-1:0] pstrb_0,
	input  logic psel_1,
	input  logic penable_1,
	input  logic pwrite_1,
	input  logic [31:0] paddr_1,
	input  logic [mpmc_cfg_pkg::ch_width[1]-1:0] pwdata_1,
	input  logic [mpmc_cfg_pkg::ch_width[1]/8-1:0] pstrb_1,
	input  logic psel_2,
	input  logic penable_2,
	input  logic pwrite_2,
	input  logic [31:0] paddr_2,
	input  logic [mpmc_cfg_pkg::ch_width[2]-1:0] pwdata_2,
	input  logic [mpmc_cfg_pkg::ch_width[2]/8-1:0] pstrb_2,
	input  logic psel_3,
	input  logic penable_3,
	input  logic pwrite_3,
	input  logic [31:0] paddr_3,
	input  logic [mpmc_cfg_pkg::ch_width[3]-1:0] pwdata_3,
	input  logic [mpmc_cfg_pkg::ch_width[3]/8-1:0] pstrb_3,
	input  logic [mpmc_cfg_pkg::num_channels-1:0] done,
	output logic req_valid,
	output mpmc_cfg_pkg::ch_id_t req_ch,
	output logic req_write,
	output logic [11:0] req_addr,
	output logic [8*mpmc_cfg_pkg::line_bytes-1:0] req_data,
	output logic [mpmc_cfg_pkg::line_bytes-1:0] req_strb
);
	import mpmc_cfg_pkg::*;

	logic [num_channels-1:0] access;
	logic [num_channels-1:0] write_vec;
	logic [11:0] addr_vec [num_channels];
	logic [8*line_bytes-1:0] data_vec [num_channels];
	logic [line_bytes-1:0] strb_vec [num_channels];
	logic [num_channels-1:0] in_flight;
	logic [num_channels-1:0] pending;
	logic [num_channels-1:0] grant_onehot;
	logic grant_valid;
	ch_id_t grant_ch;
	ch_id_t rr_ptr;

	// ============================================================
	// Channel views
	// ============================================================

	// A channel is in its APB access phase when both psel and penable are up
	assign access = {psel_3 & penable_3, psel_2 & penable_2,
		psel_1 & penable_1, psel_0 & penable_0};
	assign write_vec = {pwrite_3, pwrite_2, pwrite_1, pwrite_0};

	// Only the line index and byte-in-line bits are kept
	assign addr_vec[0] = paddr_0[11:0];
	assign addr_vec[1] = paddr_1[11:0];
	assign addr_vec[2] = paddr_2[11:0];
	assign addr_vec[3] = paddr_3[11:0];

	// Narrow channels are zero extended to line width, low aligned
	assign data_vec[0] = pwdata_0;
	assign data_vec[1] = {{(8*line_bytes-ch_width[1]){1'b0}}, pwdata_1};
	assign data_vec[2] = {{(8*line_bytes-ch_width[2]){1'b0}}, pwdata_2};
	assign data_vec[3] = {{(8*line_bytes-ch_width[3]){1'b0}}, pwdata_3};
	assign strb_vec[0] = pstrb_0;
	assign strb_vec[1] = {{(line_bytes-ch_width[1]/8){1'b0}}, pstrb_1};
	assign strb_vec[2] = {{(line_bytes-ch_width[2]/8){1'b0}}, pstrb_2};
	assign strb_vec[3] = {{(line_bytes-ch_width[3]/8){1'b0}}, pstrb_3};

	// A channel whose request is already in the pipeline keeps its access
	// phase open until pready, so it must not be granted a second time
	assign pending = access & ~in_flight;

	// ============================================================
	// Round-robin grant
	// ============================================================

	// Search starts at rr_ptr and walks upward with wrap
	// The loop runs from the far end so the nearest pending channel wins
	always_comb begin
		ch_id_t cand;
		grant_valid = 1'b0;
		grant_ch = rr_ptr;
		grant_onehot = '0;
		for (int i = num_channels - 1; i >= 0; i--) begin
			cand = rr_ptr + ch_id_t'(i);
			if (pending[cand]) begin
				grant_valid = 1'b1;
				grant_ch = cand;
			end
		end
		if (grant_valid)
			grant_onehot[grant_ch] = 1'b1;
	end

	// In-flight bits are set on grant and dropped the edge after done
	// A channel cannot be granted and done on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			req_valid <= 1'b0;
			in_flight <= '0;
			rr_ptr <= '0;
		end else begin
			req_valid <= grant_valid;
			in_flight <= (in_flight & ~done) | grant_onehot;
			if (grant_valid)
				rr_ptr <= grant_ch + ch_id_t'(1);
		end
	end

	// Capture of the granted request for the mask stage
	always_ff @(posedge clk) begin
		if (grant_valid) begin
			req_ch <= grant_ch;
			req_write <= write_vec[grant_ch];
			req_addr <= addr_vec[grant_ch];
			req_data <= data_vec[grant_ch];
			req_strb <= strb_vec[grant_ch];
		end
	end

endmodule

//--- hw/mpmc_read_align.sv
module mpmc_read_align (
	input  logic clk,
	input  logic reset,
	input  logic rd_valid,
	input  mpmc_cfg_pkg::ch_id_t rd_ch,
	input  logic [3:0] rd_lane,
	input  mpmc_line_pkg::mpmc_line_t rd_line,
	output logic pready_0,
	output logic [mpmc_cfg_pkg::ch_width[0]-1:0] prdata_0,
	output logic pready_1,
	output logic [mpmc_cfg_pkg::ch_width[1]-1:0] prdata_1,
	output logic pready_2,
	output logic [mpmc_cfg_pkg::ch_width[2]-1:0] prdata_2,
	output logic pready_3,
	output logic [mpmc_cfg_pkg::ch_width[3]-1:0] prdata_3,
	output logic [mpmc_cfg_pkg::num_channels-1:0] done
);
	import mpmc_cfg_pkg::*;

	logic [num_channels-1:0] hit;
	logic [ch_width[1]-1:0] lane_dword;
	logic [ch_width[2]-1:0] lane_word;
	logic [ch_width[3]-1:0] lane_byte;

	// Lane pick through the line views
	// The lane number indexes the view that matches the channel width
	assign lane_dword = rd_line.dwords[rd_lane[0]];
	assign lane_word = rd_line.words[rd_lane[1:0]];
	assign lane_byte = rd_line.bytes[rd_lane];

	// One-hot decode of the completing channel
	always_comb begin
		hit = '0;
		if (rd_valid)
			hit[rd_ch] = 1'b1;
	end

	// ============================================================
	// Completion
	// ============================================================

	// done doubles as the pready vector and lasts one cycle per request
	always_ff @(posedge clk) begin
		if (reset)
			done <= '0;
		else
			done <= hit;
	end

	assign pready_0 = done[0];
	assign pready_1 = done[1];
	assign pready_2 = done[2];
	assign pready_3 = done[3];

	// Read data only moves for the channel that completes
	always_ff @(posedge clk) begin
		if (hit[0])
			prdata_0 <= rd_line;
		if (hit[1])
			prdata_1 <= lane_dword;
		if (hit[2])
			prdata_2 <= lane_word;
		if (hit[3])
			prdata_3 <= lane_byte;
	end

endmodule

//--- hw/mpmc_top.sv
module mpmc_top (
	input  logic clk,
	input  logic reset,
	input  logic psel_0,
	input  logic penable_0,
	input  logic pwrite_0,
	input  logic [31:0] paddr_0,
	input  logic [mpmc_cfg_pkg::ch_width[0]-1:0] pwdata_0,
	input  logic [mpmc_cfg_pkg::ch_width[0]/8-1:0] pstrb_0,
	output logic pready_0,
	output logic [mpmc_cfg_pkg::ch_width[0]-1:0] prdata_0,
	input  logic psel_1,
	input  logic penable_1,
	input  logic pwrite_1,
	input  logic [31:0] paddr_1,
	input  logic [mpmc_cfg_pkg::ch_width[1]-1:0] pwdata_1,
	input  logic [mpmc_cfg_pkg::ch_width[1]/8-1:0] pstrb_1,
	output logic pready_1,
	output logic [mpmc_cfg_pkg::ch_width[1]-1:0] prdata_1,
	input  logic psel_2,
	input  logic penable_2,
	input  logic pwrite_2,
	input  logic [31:0] paddr_2,
	input  logic [mpmc_cfg_pkg::ch_width[2]-1:0] pwdata_2,
	input  logic [mpmc_cfg_pkg::ch_width[2]/8-1:0] pstrb_2,
	output logic pready_2,
	output logic [mpmc_cfg_pkg::ch_width[2]-1:0] prdata_2,
	input  logic psel_3,
	input  logic penable_3,
	input  logic pwrite_3,
	input  logic [31:0] paddr_3,
	input  logic [mpmc_cfg_pkg::ch_width[3]-1:0] pwdata_3,
	input  logic [mpmc_cfg_pkg::ch_width[3]/8-1:0] pstrb_3,
	output logic pready_3,
	output logic [mpmc_cfg_pkg::ch_width[3]-1:0] prdata_3
);
	import mpmc_cfg_pkg::*;
	import mpmc_line_pkg::*;

	// Grant to mask
	logic req_valid;
	ch_id_t req_ch;
	logic req_write;
	logic [11:0] req_addr;
	logic [8*line_bytes-1:0] req_data;
	logic [line_bytes-1:0] req_strb;

	// Mask to store
	logic st_valid;
	ch_id_t st_ch;
	logic st_write;
	logic [line_index_bits-1:0] st_index;
	logic [3:0] st_lane;
	byte_en_t st_byte_en;
	mpmc_line_t st_data;

	// Store to read alignment
	logic rd_valid;
	ch_id_t rd_ch;
	logic [3:0] rd_lane;
	mpmc_line_t rd_line;

	// Completion back to the arbiter
	logic [num_channels-1:0] done;

	mpmc_port_select port_select_inst (
		.clk, .reset,
		.psel_0, .penable_0, .pwrite_0, .paddr_0, .pwdata_0, .pstrb_0,
		.psel_1, .penable_1, .pwrite_1, .paddr_1, .pwdata_1, .pstrb_1,
		.psel_2, .penable_2, .pwrite_2, .paddr_2, .pwdata_2, .pstrb_2,
		.psel_3, .penable_3, .pwrite_3, .paddr_3, .pwdata_3, .pstrb_3,
		.done,
		.req_valid, .req_ch, .req_write, .req_addr, .req_data, .req_strb
	);

	mpmc_write_mask write_mask_inst (
		.clk, .reset,
		.req_valid, .req_ch, .req_write, .req_addr, .req_data, .req_strb,
		.st_valid, .st_ch, .st_write, .st_index, .st_lane, .st_byte_en, .st_data
	);

	mpmc_line_store line_store_inst (
		.clk,
		.st_valid, .st_ch, .st_write, .st_index, .st_lane, .st_byte_en, .st_data,
		.rd_valid, .rd_ch, .rd_lane, .rd_line
	);

	mpmc_read_align read_align_inst (
		.clk, .reset,
		.rd_valid, .rd_ch, .rd_lane, .rd_line,
		.pready_0, .prdata_0, .pready_1, .prdata_1,
		.pready_2, .prdata_2, .pready_3, .prdata_3,
		.done
	);

endmodule

//--- hw/mpmc_write_mask.sv
module mpmc_write_mask (
	input  logic clk,
	input  logic reset,
	input  logic req_valid,
	input  mpmc_cfg_pkg::ch_id_t req_ch,
	input  logic req_write,
	input  logic [11:0] req_addr,
	input  logic [8*mpmc_cfg_pkg::line_bytes-1:0] req_data,
	input  logic [mpmc_cfg_pkg::line_bytes-1:0] req_strb,
	output logic st_valid,
	output mpmc_cfg_pkg::ch_id_t st_ch,
	output logic st_write,
	output logic [mpmc_cfg_pkg::line_index_bits-1:0] st_index,
	output logic [3:0] st_lane,
	output mpmc_line_pkg::byte_en_t st_byte_en,
	output mpmc_line_pkg::mpmc_line_t st_data
);
	import mpmc_cfg_pkg::*;
	import mpmc_line_pkg::*;

	int lane_width;
	logic [3:0] lane;
	byte_en_t byte_en;
	logic [8*line_bytes-1:0] lane_data;

	// ============================================================
	// Lane decode
	// ============================================================

	// The channel width decides how many low address bits pick the lane
	// Strobes slide up by lane times the lane size in bytes
	// Data is copied into every lane so the store needs no shifter
	always_comb begin
		lane_width = ch_width[req_ch];
		if (lane_width == 128) begin
			lane = 4'd0;
			byte_en = req_strb;
			lane_data = req_data;
		end else if (lane_width == 64) begin
			lane = {3'b000, req_addr[3]};
			byte_en = {8'h00, req_strb[7:0]} << {req_addr[3], 3'b000};
			lane_data = {2{req_data[63:0]}};
		end else if (lane_width == 32) begin
			lane = {2'b00, req_addr[3:2]};
			byte_en = {12'h000, req_strb[3:0]} << {req_addr[3:2], 2'b00};
			lane_data = {4{req_data[31:0]}};
		end else begin
			// On the byte channel every address bit below the index is the lane
			lane = req_addr[3:0];
			byte_en = {15'd0, req_strb[0]} << req_addr[3:0];
			lane_data = {16{req_data[7:0]}};
		end
		// Reads must leave the line untouched
		if (!req_write)
			byte_en = '0;
	end

	// ============================================================
	// Stage register
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset)
			st_valid <= 1'b0;
		else
			st_valid <= req_valid;
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			st_ch <= req_ch;
			st_write <= req_write;
			st_index <= req_addr[11:4];
			st_lane <= lane;
			st_byte_en <= byte_en;
			st_data <= lane_data;
		end
	end

endmodule
